//--- hdl/tlp_pkg.sv
package tlp_pkg;

  // --------------------
  // header layout, 3DW request in bits 127:32
  localparam int HDR_W = 128;

  localparam int FMT_TYPE_MSB = 127;
  localparam int FMT_TYPE_LSB = 120;
  localparam int LEN_MSB      = 105;
  localparam int LEN_LSB      = 96;

  localparam int REQ_ID_LSB   = 80;  // 16 bits
  localparam int TAG_LSB      = 72;  // 8 bits
  localparam int LAST_BE_LSB  = 68;  // 4 bits
  localparam int FIRST_BE_LSB = 64;  // 4 bits
  localparam int ADDR_LSB     = 32;  // 32-bit address word, bits 1:0 reserved

  // completion DW1/DW2 fields
  localparam int CPL_BCNT_LSB   = 64;  // 12-bit byte count
  localparam int CPL_REQ_ID_LSB = 48;
  localparam int CPL_TAG_LSB    = 40;
  localparam int CPL_LADDR_LSB  = 32;  // 7-bit lower address

  // --------------------
  // format/type codes
  localparam logic [7:0] FT_MWR32 = 8'h40;
  localparam logic [7:0] FT_MRD32 = 8'h00;
  localparam logic [7:0] FT_CPLD  = 8'h4A;

  // credit class reported with each TX TLP
  typedef enum logic [1:0] {
    CDT_POSTED    = 2'b00,
    CDT_NONPOSTED = 2'b01,
    CDT_CPL       = 2'b11
  } cdt_class_e;

endpackage

//--- hdl/pio_pkg.sv
package pio_pkg;

  // data part of a TX beat, same as the default stream width
  localparam int TX_DATA_W = 256;

  // one queued memory read
  typedef struct packed {
    logic [15:0] req_id;
    logic [7:0]  tag;
    logic [7:0]  reg_idx;
    logic [6:0]  lower_addr;
  } rd_req_t;

  // one TX beat as held in the output queue
  typedef struct packed {
    logic [tlp_pkg::HDR_W-1:0] hdr;
    logic [TX_DATA_W-1:0]      data;
  } tx_beat_t;

endpackage

//--- hdl/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
  parameter type T     = logic [7:0],
  parameter int  DEPTH = 4
) (
  input  logic clk,
  input  logic srstn,
  input  logic push_i,
  input  T     data_i,
  output logic full_o,
  input  logic pop_i,
  output T     data_o,
  output logic empty_o
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam logic [AW:0]   CNT_FULL = (AW+1)'(DEPTH);
  localparam logic [AW-1:0] PTR_LAST = AW'(DEPTH - 1);

  T mem [DEPTH];

  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;
  logic          do_push;
  logic          do_pop;

  assign full_o  = (count == CNT_FULL);
  assign empty_o = (count == '0);
  assign do_push = push_i & ~full_o;  // push into a full queue is ignored
  assign do_pop  = pop_i & ~empty_o;
  assign data_o  = mem[rd_ptr];       // first word falls through

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= data_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!srstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- hdl/rx_decoder.sv
`timescale 1ns/1ps

module rx_decoder #(
  parameter int DATA_W = 256
) (
  input  logic                      clk,
  input  logic                      srstn,
  input  logic                      rx_st_valid_i,
  input  logic                      rx_st_sop_i,
  input  logic                      rx_st_eop_i,
  input  logic [tlp_pkg::HDR_W-1:0] rx_st_header_i,
  input  logic [DATA_W-1:0]         rx_st_data_i,
  input  logic [2:0]                rx_st_bar_i,
  output logic                      rx_st_ready_o,
  input  logic                      req_full_i,
  output logic                      req_push_o,
  output pio_pkg::rd_req_t          req_data_o,
  output logic                      wr_en_o,
  output logic [7:0]                wr_idx_o,
  output logic [63:0]               wr_data_o,
  output logic [7:0]                wr_be_o,
  output logic [15:0]               rx_drop_cnt_o
);

  logic        accept;
  logic        single;
  logic        bar0;
  logic [7:0]  fmt_type;
  logic [9:0]  len;
  logic [31:0] addr;
  logic [3:0]  first_be;
  logic [3:0]  last_be;
  logic        is_mwr;
  logic        is_mrd;
  logic        stg_rd;  // read waiting in the stage for a FIFO slot

  // --------------------
  // decode of the incoming beat
  assign fmt_type = rx_st_header_i[tlp_pkg::FMT_TYPE_MSB:tlp_pkg::FMT_TYPE_LSB];
  assign len      = rx_st_header_i[tlp_pkg::LEN_MSB:tlp_pkg::LEN_LSB];
  assign addr     = rx_st_header_i[tlp_pkg::ADDR_LSB +: 32];
  assign first_be = rx_st_header_i[tlp_pkg::FIRST_BE_LSB +: 4];
  assign last_be  = rx_st_header_i[tlp_pkg::LAST_BE_LSB +: 4];
  assign single   = rx_st_sop_i & rx_st_eop_i;
  assign bar0     = (rx_st_bar_i == 3'd0);
  assign is_mwr   = single & bar0 & (fmt_type == tlp_pkg::FT_MWR32);
  assign is_mrd   = single & bar0 & (fmt_type == tlp_pkg::FT_MRD32);

  // the stage itself is the reserved slot: a staged read holds while the FIFO is full
  assign rx_st_ready_o = ~req_full_i;
  assign accept        = rx_st_valid_i & rx_st_ready_o;
  assign req_push_o    = stg_rd & ~req_full_i;

  // --------------------
  // register stage
  always_ff @(posedge clk) begin
    if (!srstn) begin
      wr_en_o       <= 1'b0;
      stg_rd        <= 1'b0;
      rx_drop_cnt_o <= '0;
    end else begin
      wr_en_o <= accept & is_mwr;
      stg_rd  <= accept ? is_mrd : (stg_rd & req_full_i);
      if (accept && !is_mwr && !is_mrd) begin
        rx_drop_cnt_o <= rx_drop_cnt_o + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      wr_idx_o              <= addr[10:3];  // one register per 8 bytes
      wr_data_o             <= rx_st_data_i[63:0];
      wr_be_o[3:0]          <= first_be;
      wr_be_o[7:4]          <= (len == 10'd2) ? last_be : 4'h0;
      req_data_o.req_id     <= rx_st_header_i[tlp_pkg::REQ_ID_LSB +: 16];
      req_data_o.tag        <= rx_st_header_i[tlp_pkg::TAG_LSB +: 8];
      req_data_o.reg_idx    <= addr[10:3];
      req_data_o.lower_addr <= addr[6:0];
    end
  end

endmodule

//--- hdl/bar_regfile.sv
`timescale 1ns/1ps

module bar_regfile #(
  parameter int REG_NUM = 16
) (
  input  logic        clk,
  input  logic        srstn,
  input  logic        wr_en_i,
  input  logic [7:0]  wr_idx_i,
  input  logic [63:0] wr_data_i,
  input  logic [7:0]  wr_be_i,
  input  logic [7:0]  rd_idx_i,
  output logic [63:0] rd_data_o
);

  localparam int IDX_W = (REG_NUM > 1) ? $clog2(REG_NUM) : 1;
  localparam logic [8:0] IDX_END = 9'(REG_NUM);

  logic [63:0] regs [REG_NUM];
  logic        wr_hit;
  logic        rd_hit;

  // indices past the bank write nothing and read zero
  assign wr_hit = wr_en_i & ({1'b0, wr_idx_i} < IDX_END);
  assign rd_hit = ({1'b0, rd_idx_i} < IDX_END);

  assign rd_data_o = rd_hit ? regs[rd_idx_i[IDX_W-1:0]] : 64'h0;

  always_ff @(posedge clk) begin
    if (!srstn) begin
      for (int i = 0; i < REG_NUM; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_hit) begin
      for (int b = 0; b < 8; b++) begin
        if (wr_be_i[b]) begin  // byte lane b
          regs[wr_idx_i[IDX_W-1:0]][8*b +: 8] <= wr_data_i[8*b +: 8];
        end
      end
    end
  end

endmodule

//--- hdl/cpl_builder.sv
`timescale 1ns/1ps

module cpl_builder (
  input  logic                          clk,
  input  logic                          srstn,
  input  logic                          req_empty_i,
  input  pio_pkg::rd_req_t              req_data_i,
  output logic                          req_pop_o,
  output logic [7:0]                    rd_idx_o,
  input  logic [63:0]                   rd_data_i,
  output logic                          cpl_valid_o,
  output logic [tlp_pkg::HDR_W-1:0]     cpl_header_o,
  output logic [pio_pkg::TX_DATA_W-1:0] cpl_data_o,
  input  logic                          cpl_ready_i
);

  logic [tlp_pkg::HDR_W-1:0] hdr_d;

  // take the next request once the held beat is gone or leaving
  assign req_pop_o = ~req_empty_i & (~cpl_valid_o | cpl_ready_i);
  assign rd_idx_o  = req_data_i.reg_idx;

  // --------------------
  // CplD header, completer ID 0 and status successful
  always_comb begin
    hdr_d = '0;
    hdr_d[tlp_pkg::FMT_TYPE_MSB:tlp_pkg::FMT_TYPE_LSB] = tlp_pkg::FT_CPLD;
    hdr_d[tlp_pkg::LEN_MSB:tlp_pkg::LEN_LSB]           = 10'd2;  // two dwords
    hdr_d[tlp_pkg::CPL_BCNT_LSB +: 12]                 = 12'd8;
    hdr_d[tlp_pkg::CPL_REQ_ID_LSB +: 16]               = req_data_i.req_id;
    hdr_d[tlp_pkg::CPL_TAG_LSB +: 8]                   = req_data_i.tag;
    hdr_d[tlp_pkg::CPL_LADDR_LSB +: 7]                 = req_data_i.lower_addr;
  end

  always_ff @(posedge clk) begin
    if (!srstn) begin
      cpl_valid_o <= 1'b0;
    end else if (req_pop_o) begin
      cpl_valid_o <= 1'b1;
    end else if (cpl_ready_i) begin
      cpl_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (req_pop_o) begin
      cpl_header_o <= hdr_d;
      cpl_data_o   <= {{(pio_pkg::TX_DATA_W-64){1'b0}}, rd_data_i};  // register in the low qword
    end
  end

endmodule

//--- hdl/tx_port.sv
`timescale 1ns/1ps

module tx_port #(
  parameter int TIMEOUT_CYCLES = 512
) (
  input  logic                          clk,
  input  logic                          srstn,
  input  logic                          cpl_valid_i,
  input  logic [tlp_pkg::HDR_W-1:0]     cpl_header_i,
  input  logic [pio_pkg::TX_DATA_W-1:0] cpl_data_i,
  output logic                          cpl_ready_o,
  output logic                          tx_st_valid_o,
  output logic                          tx_st_sop_o,
  output logic                          tx_st_eop_o,
  output logic [tlp_pkg::HDR_W-1:0]     tx_st_header_o,
  output logic [pio_pkg::TX_DATA_W-1:0] tx_st_data_o,
  input  logic                          tx_st_ready_i,
  output logic                          tx_cdt_valid_o,
  output logic [9:0]                    tx_cdt_len_o,
  output tlp_pkg::cdt_class_e           tx_cdt_type_o,
  output logic                          tx_rdy_timeout_o
);

  localparam int CNT_W = $clog2(TIMEOUT_CYCLES + 1);
  localparam logic [CNT_W-1:0] LIMIT = CNT_W'(TIMEOUT_CYCLES);

  pio_pkg::tx_beat_t   beat_in;
  pio_pkg::tx_beat_t   beat_out;
  logic                q_full;
  logic                q_empty;
  logic                xfer;
  logic [7:0]          out_ft;
  tlp_pkg::cdt_class_e cdt_class;
  logic [CNT_W-1:0]    rdy_timer;

  assign beat_in.hdr  = cpl_header_i;
  assign beat_in.data = cpl_data_i;
  assign cpl_ready_o  = ~q_full;

  // two-beat output queue, head drives the link
  sync_fifo #(
    .T     (pio_pkg::tx_beat_t),
    .DEPTH (2)
  ) tx_q_i (
    .clk     (clk),
    .srstn   (srstn),
    .push_i  (cpl_valid_i),
    .data_i  (beat_in),
    .full_o  (q_full),
    .pop_i   (xfer),
    .data_o  (beat_out),
    .empty_o (q_empty)
  );

  assign tx_st_valid_o  = ~q_empty;
  assign tx_st_sop_o    = ~q_empty;  // single-beat TLPs
  assign tx_st_eop_o    = ~q_empty;
  assign tx_st_header_o = beat_out.hdr;
  assign tx_st_data_o   = beat_out.data;
  assign xfer           = tx_st_valid_o & tx_st_ready_i;
  assign out_ft         = beat_out.hdr[tlp_pkg::FMT_TYPE_MSB:tlp_pkg::FMT_TYPE_LSB];

  always_comb begin
    case (out_ft)
      tlp_pkg::FT_CPLD:  cdt_class = tlp_pkg::CDT_CPL;
      tlp_pkg::FT_MRD32: cdt_class = tlp_pkg::CDT_NONPOSTED;
      default:           cdt_class = tlp_pkg::CDT_POSTED;
    endcase
  end

  // --------------------
  // credit report and ready watchdog
  always_ff @(posedge clk) begin
    if (!srstn) begin
      tx_cdt_valid_o   <= 1'b0;
      rdy_timer        <= '0;
      tx_rdy_timeout_o <= 1'b0;
    end else begin
      tx_cdt_valid_o <= xfer;
      if (tx_st_ready_i) begin
        rdy_timer <= '0;
      end else if (rdy_timer != LIMIT) begin
        rdy_timer <= rdy_timer + 1'b1;  // saturates at the limit
      end
      if (rdy_timer == LIMIT) begin
        tx_rdy_timeout_o <= 1'b1;  // sticky
      end
    end
  end

  always_ff @(posedge clk) begin
    if (xfer) begin
      tx_cdt_len_o  <= beat_out.hdr[tlp_pkg::LEN_MSB:tlp_pkg::LEN_LSB];
      tx_cdt_type_o <= cdt_class;
    end
  end

endmodule

//--- hdl/pio_top.sv
`timescale 1ns/1ps

module pio_top #(
  parameter int DATA_W         = 256,
  parameter int REG_NUM        = 16,
  parameter int REQ_DEPTH      = 4,
  parameter int TIMEOUT_CYCLES = 512
) (
  input  logic                      clk,
  input  logic                      srstn,
  input  logic                      rx_st_valid_i,
  input  logic                      rx_st_sop_i,
  input  logic                      rx_st_eop_i,
  input  logic [tlp_pkg::HDR_W-1:0] rx_st_header_i,
  input  logic [DATA_W-1:0]         rx_st_data_i,
  input  logic [2:0]                rx_st_bar_i,
  output logic                      rx_st_ready_o,
  output logic                      tx_st_valid_o,
  output logic                      tx_st_sop_o,
  output logic                      tx_st_eop_o,
  output logic [tlp_pkg::HDR_W-1:0] tx_st_header_o,
  output logic [DATA_W-1:0]         tx_st_data_o,
  input  logic                      tx_st_ready_i,
  output logic                      tx_cdt_valid_o,
  output logic [9:0]                tx_cdt_len_o,
  output tlp_pkg::cdt_class_e       tx_cdt_type_o,
  output logic                      tx_rdy_timeout_o,
  output logic [15:0]               rx_drop_cnt_o
);

  logic                          req_push;
  logic                          req_full;
  logic                          req_pop;
  logic                          req_empty;
  pio_pkg::rd_req_t              req_wdata;
  pio_pkg::rd_req_t              req_rdata;
  logic                          wr_en;
  logic [7:0]                    wr_idx;
  logic [63:0]                   wr_data;
  logic [7:0]                    wr_be;
  logic [7:0]                    rd_idx;
  logic [63:0]                   rd_data;
  logic                          cpl_valid;
  logic [tlp_pkg::HDR_W-1:0]     cpl_header;
  logic [pio_pkg::TX_DATA_W-1:0] cpl_data;
  logic                          cpl_ready;

  rx_decoder #(.DATA_W(DATA_W)) rx_dec_i (
    .clk, .srstn,
    .rx_st_valid_i, .rx_st_sop_i, .rx_st_eop_i, .rx_st_header_i,
    .rx_st_data_i, .rx_st_bar_i, .rx_st_ready_o,
    .req_full_i (req_full), .req_push_o (req_push), .req_data_o (req_wdata),
    .wr_en_o (wr_en), .wr_idx_o (wr_idx), .wr_data_o (wr_data), .wr_be_o (wr_be),
    .rx_drop_cnt_o
  );

  bar_regfile #(.REG_NUM(REG_NUM)) bar0_i (
    .clk, .srstn,
    .wr_en_i (wr_en), .wr_idx_i (wr_idx), .wr_data_i (wr_data), .wr_be_i (wr_be),
    .rd_idx_i (rd_idx), .rd_data_o (rd_data)
  );

  // read request queue
  sync_fifo #(.T(pio_pkg::rd_req_t), .DEPTH(REQ_DEPTH)) req_q_i (
    .clk, .srstn,
    .push_i (req_push), .data_i (req_wdata), .full_o (req_full),
    .pop_i (req_pop), .data_o (req_rdata), .empty_o (req_empty)
  );

  cpl_builder cpl_i (
    .clk, .srstn,
    .req_empty_i (req_empty), .req_data_i (req_rdata), .req_pop_o (req_pop),
    .rd_idx_o (rd_idx), .rd_data_i (rd_data),
    .cpl_valid_o (cpl_valid), .cpl_header_o (cpl_header), .cpl_data_o (cpl_data),
    .cpl_ready_i (cpl_ready)
  );

  tx_port #(.TIMEOUT_CYCLES(TIMEOUT_CYCLES)) tx_i (
    .clk, .srstn,
    .cpl_valid_i (cpl_valid), .cpl_header_i (cpl_header), .cpl_data_i (cpl_data),
    .cpl_ready_o (cpl_ready),
    .tx_st_valid_o, .tx_st_sop_o, .tx_st_eop_o, .tx_st_header_o, .tx_st_data_o,
    .tx_st_ready_i, .tx_cdt_valid_o, .tx_cdt_len_o, .tx_cdt_type_o, .tx_rdy_timeout_o
  );

endmodule

//--- dv/pio_tb_assert.sv
`timescale 1ns/1ps

module pio_tb_assert (
  input logic                      clk,
  input logic                      srstn,
  input logic                      rx_valid_i,
  input logic                      rx_ready_i,
  input logic                      wr_en_i,
  input logic [15:0]               drop_cnt_i,
  input logic                      tx_valid_i,
  input logic                      tx_ready_i,
  input logic [tlp_pkg::HDR_W-1:0] tx_header_i,
  input logic [255:0]              tx_data_i,
  input logic                      cdt_valid_i
);

  // --------------------
  // TX stream
  assert property (@(posedge clk) disable iff (!srstn)
    tx_valid_i && !tx_ready_i |=> tx_valid_i && $stable(tx_header_i) && $stable(tx_data_i))
    else $error("TX beat changed or dropped while waiting for ready");

  assert property (@(posedge clk) disable iff (!srstn)
    cdt_valid_i |-> $past(tx_valid_i && tx_ready_i))
    else $error("credit report without a TX transfer in the cycle before");

  // --------------------
  // RX stream, a taken beat shows up as a register write or a drop count
  assert property (@(posedge clk) disable iff (!srstn)
    wr_en_i |-> $past(rx_valid_i && rx_ready_i))
    else $error("register write from an RX beat taken while ready was low");

  assert property (@(posedge clk) disable iff (!srstn)
    (drop_cnt_i != $past(drop_cnt_i)) |-> $past(rx_valid_i && rx_ready_i))
    else $error("drop counted for an RX beat taken while ready was low");

endmodule

//--- dv/pio_tb.sv
`timescale 1ns/1ps

module pio_tb;

  localparam int DATA_W     = 256;
  localparam int REG_NUM    = 16;
  localparam int REQ_DEPTH  = 4;
  localparam int TIMEOUT    = 64;  // short limit keeps the watchdog test brief
  localparam int RST_CYCLES = 16;
  localparam int MAX_WAIT   = 40;  // cycles allowed for one handshake
  localparam int TLP_NUM    = 2 * REG_NUM + 16 + 3 + 16;
  localparam int RUN_CYCLES = RST_CYCLES + 2 * TLP_NUM * MAX_WAIT + 2 * TIMEOUT + 200;

  logic                      clk;
  logic                      srstn;
  logic                      rx_st_valid_i;
  logic                      rx_st_sop_i;
  logic                      rx_st_eop_i;
  logic [tlp_pkg::HDR_W-1:0] rx_st_header_i;
  logic [DATA_W-1:0]         rx_st_data_i;
  logic [2:0]                rx_st_bar_i;
  logic                      rx_st_ready_o;
  logic                      tx_st_valid_o;
  logic                      tx_st_sop_o;
  logic                      tx_st_eop_o;
  logic [tlp_pkg::HDR_W-1:0] tx_st_header_o;
  logic [DATA_W-1:0]         tx_st_data_o;
  logic                      tx_st_ready_i;
  logic                      tx_cdt_valid_o;
  logic [9:0]                tx_cdt_len_o;
  tlp_pkg::cdt_class_e       tx_cdt_type_o;
  logic                      tx_rdy_timeout_o;
  logic [15:0]               rx_drop_cnt_o;

  integer      seed = 22;
  int          err_cnt = 0;
  int          test_cnt = 0;
  int          xfer_cnt = 0;  // TX transfers seen on the link
  int          cdt_cnt = 0;
  int          cpl_cnt = 0;   // completions the tests have taken
  logic        xfer_d = 1'b0;
  logic [63:0] model [REG_NUM];  // expected register contents

  pio_top #(
    .DATA_W         (DATA_W),
    .REG_NUM        (REG_NUM),
    .REQ_DEPTH      (REQ_DEPTH),
    .TIMEOUT_CYCLES (TIMEOUT)
  ) dut_i (.*);

  bind pio_top pio_tb_assert assert_i (
    .clk         (clk),
    .srstn       (srstn),
    .rx_valid_i  (rx_st_valid_i),
    .rx_ready_i  (rx_st_ready_o),
    .wr_en_i     (wr_en),
    .drop_cnt_i  (rx_drop_cnt_o),
    .tx_valid_i  (tx_st_valid_o),
    .tx_ready_i  (tx_st_ready_i),
    .tx_header_i (tx_st_header_o),
    .tx_data_i   (tx_st_data_o),
    .cdt_valid_i (tx_cdt_valid_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // --------------------
  // helpers
  task automatic step_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic report_mismatch(input string name, input logic [255:0] got,
                                 input logic [255:0] exp);
    $display("FAIL t=%0t %s got %0h expected %0h", $time, name, got, exp);
    err_cnt++;
  endtask

  task automatic report_error(input string what);
    $display("ERROR t=%0t %s", $time, what);
    err_cnt++;
  endtask

  task automatic finish_test(input string name, input int err_start);
    test_cnt++;
    if (err_cnt == err_start) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, err_cnt - err_start);
    end
  endtask

  function automatic logic [127:0] req_header(input logic [7:0] ft, input logic [9:0] len,
                                              input logic [15:0] rid, input logic [7:0] tag,
                                              input logic [3:0] lbe, input logic [3:0] fbe,
                                              input logic [31:0] addr);
    logic [127:0] h;
    h = '0;
    h[tlp_pkg::FMT_TYPE_MSB:tlp_pkg::FMT_TYPE_LSB] = ft;
    h[tlp_pkg::LEN_MSB:tlp_pkg::LEN_LSB] = len;
    h[tlp_pkg::REQ_ID_LSB +: 16] = rid;
    h[tlp_pkg::TAG_LSB +: 8] = tag;
    h[tlp_pkg::LAST_BE_LSB +: 4] = lbe;
    h[tlp_pkg::FIRST_BE_LSB +: 4] = fbe;
    h[tlp_pkg::ADDR_LSB +: 32] = addr;
    return h;
  endfunction

  // expected CplD for an 8-byte register read from completer 0 with successful status
  function automatic logic [127:0] cpl_header(input logic [15:0] rid, input logic [7:0] tag,
                                              input logic [6:0] laddr);
    logic [127:0] h;
    h = '0;
    h[tlp_pkg::FMT_TYPE_MSB:tlp_pkg::FMT_TYPE_LSB] = tlp_pkg::FT_CPLD;
    h[tlp_pkg::LEN_MSB:tlp_pkg::LEN_LSB] = 10'd2;
    h[tlp_pkg::CPL_BCNT_LSB +: 12] = 12'd8;
    h[tlp_pkg::CPL_REQ_ID_LSB +: 16] = rid;
    h[tlp_pkg::CPL_TAG_LSB +: 8] = tag;
    h[tlp_pkg::CPL_LADDR_LSB +: 7] = laddr;
    return h;
  endfunction

  task automatic send_tlp(input logic [127:0] hdr, input logic [63:0] dw,
                          input logic [2:0] bar_num);
    int wait_cnt;
    wait_cnt = 0;
    rx_st_valid_i  = 1'b1;
    rx_st_sop_i    = 1'b1;
    rx_st_eop_i    = 1'b1;
    rx_st_header_i = hdr;
    rx_st_data_i   = {{(DATA_W-64){1'b0}}, dw};
    rx_st_bar_i    = bar_num;
    while (!rx_st_ready_o && wait_cnt < MAX_WAIT) begin
      step_cycle();
      wait_cnt++;
    end
    if (!rx_st_ready_o) begin
      report_error("rx_st_ready_o stayed low, TLP was never taken");
    end
    step_cycle();  // beat transfers on this edge
    rx_st_valid_i = 1'b0;
    rx_st_sop_i   = 1'b0;
    rx_st_eop_i   = 1'b0;
  endtask

  // holds a beat on RX for a few cycles while ready is low, then withdraws it
  task automatic offer_held_off(input logic [127:0] hdr, input logic [63:0] dw,
                                input logic [2:0] bar_num, input int cycles);
    rx_st_valid_i  = 1'b1;
    rx_st_sop_i    = 1'b1;
    rx_st_eop_i    = 1'b1;
    rx_st_header_i = hdr;
    rx_st_data_i   = {{(DATA_W-64){1'b0}}, dw};
    rx_st_bar_i    = bar_num;
    for (int c = 0; c < cycles; c++) begin
      if (rx_st_ready_o) report_error("rx_st_ready_o rose while a beat was held off");
      step_cycle();
    end
    rx_st_valid_i = 1'b0;
    rx_st_sop_i   = 1'b0;
    rx_st_eop_i   = 1'b0;
  endtask

  task automatic write_reg(input logic [7:0] idx, input logic [63:0] val, input logic [9:0] len,
                           input logic [3:0] fbe, input logic [3:0] lbe);
    logic [7:0] be;
    be = {(len == 10'd2) ? lbe : 4'h0, fbe};
    send_tlp(req_header(tlp_pkg::FT_MWR32, len, 16'h0100, 8'h00, lbe, fbe, {21'h0, idx, 3'b000}),
             val, 3'd0);
    for (int b = 0; b < 8; b++) begin
      if (be[b]) model[idx][8*b +: 8] = val[8*b +: 8];
    end
  endtask

  task automatic read_reg(input logic [7:0] idx, input logic [7:0] tag, input logic [15:0] rid);
    send_tlp(req_header(tlp_pkg::FT_MRD32, 10'd2, rid, tag, 4'hF, 4'hF, {21'h0, idx, 3'b000}),
             64'h0, 3'd0);
  endtask

  task automatic expect_cpl(input logic [7:0] idx, input logic [7:0] tag, input logic [15:0] rid);
    int           wait_cnt;
    logic [127:0] exp_hdr;
    wait_cnt = 0;
    exp_hdr  = cpl_header(rid, tag, {idx[3:0], 3'b000});
    while (!tx_st_valid_o && wait_cnt < MAX_WAIT) begin
      step_cycle();
      wait_cnt++;
    end
    if (!tx_st_valid_o) begin
      report_error($sformatf("no completion arrived for tag %0h", tag));
      return;
    end
    if (tx_st_header_o !== exp_hdr) report_mismatch("tx_st_header_o", tx_st_header_o, exp_hdr);
    if (tx_st_data_o !== {192'h0, model[idx]}) begin
      report_mismatch("tx_st_data_o", tx_st_data_o, {192'h0, model[idx]});
    end
    if (!(tx_st_sop_o && tx_st_eop_o)) report_error("completion beat lacks sop or eop");
    cpl_cnt++;
    step_cycle();
  endtask

  // --------------------
  // credit report monitor sees the values from before the edge
  always @(posedge clk) begin
    if (srstn) begin
      if (tx_cdt_valid_o !== xfer_d) begin
        report_error("tx_cdt_valid_o pulse does not match the TX transfer before it");
      end
      if (tx_cdt_valid_o) begin
        cdt_cnt++;
        if (tx_cdt_len_o !== 10'd2) report_mismatch("tx_cdt_len_o", tx_cdt_len_o, 10'd2);
        if (tx_cdt_type_o !== tlp_pkg::CDT_CPL) begin
          report_mismatch("tx_cdt_type_o", tx_cdt_type_o, tlp_pkg::CDT_CPL);
        end
      end
      if (tx_st_valid_o && tx_st_ready_i) xfer_cnt++;
    end
    xfer_d = srstn && tx_st_valid_o && tx_st_ready_i;
  end

  // --------------------
  // tests
  task automatic check_reset_values();
    int err_start;
    err_start = err_cnt;
    if (tx_st_valid_o !== 1'b0) report_mismatch("tx_st_valid_o", tx_st_valid_o, 0);
    if (tx_cdt_valid_o !== 1'b0) report_mismatch("tx_cdt_valid_o", tx_cdt_valid_o, 0);
    if (tx_rdy_timeout_o !== 1'b0) report_mismatch("tx_rdy_timeout_o", tx_rdy_timeout_o, 0);
    if (rx_drop_cnt_o !== 16'h0) report_mismatch("rx_drop_cnt_o", rx_drop_cnt_o, 0);
    finish_test("reset_values", err_start);
  endtask

  task automatic full_write_read();
    int          err_start;
    logic [15:0] rid;
    err_start = err_cnt;
    for (int i = 0; i < REG_NUM; i++) begin
      write_reg(8'(i), {$random(seed), $random(seed)}, 10'd2, 4'hF, 4'hF);
    end
    for (int i = 0; i < REG_NUM; i++) begin
      rid = 16'($random(seed));
      read_reg(8'(i), 8'(8'h20 + i), rid);
      expect_cpl(8'(i), 8'(8'h20 + i), rid);
    end
    finish_test("full_write_read", err_start);
  endtask

  task automatic partial_write();
    int         err_start;
    logic [9:0] len;
    err_start = err_cnt;
    for (int k = 0; k < 8; k++) begin
      len = (k % 3 == 0) ? 10'd1 : 10'd2;  // length 1 ignores the last BE
      write_reg(8'(k), {$random(seed), $random(seed)}, len, 4'($random(seed)),
                4'($random(seed)));
    end
    for (int k = 0; k < 8; k++) begin
      read_reg(8'(k), 8'(8'h40 + k), 16'h0001);
      expect_cpl(8'(k), 8'(8'h40 + k), 16'h0001);
    end
    finish_test("partial_write", err_start);
  endtask

  task automatic unsupported_tlp();
    int          err_start;
    int          xfer_start;
    logic [15:0] drop_start;
    err_start  = err_cnt;
    xfer_start = xfer_cnt;
    drop_start = rx_drop_cnt_o;
    send_tlp(req_header(tlp_pkg::FT_MRD32, 10'd2, 16'h0002, 8'h60, 4'hF, 4'hF, 32'h8),
             64'h0, 3'd1);  // read to BAR 1
    send_tlp(req_header(8'h30, 10'd0, 16'h0002, 8'h61, 4'h0, 4'h0, 32'h0), 64'h0, 3'd0);
    send_tlp(req_header(tlp_pkg::FT_CPLD, 10'd1, 16'h0002, 8'h62, 4'h0, 4'h0, 32'h0),
             64'h0, 3'd0);
    for (int c = 0; c < 8; c++) begin
      if (tx_st_valid_o !== 1'b0) report_mismatch("tx_st_valid_o", tx_st_valid_o, 0);
      step_cycle();
    end
    if (rx_drop_cnt_o !== drop_start + 16'd3) begin
      report_mismatch("rx_drop_cnt_o", rx_drop_cnt_o, drop_start + 16'd3);
    end
    if (xfer_cnt != xfer_start) report_error("a completion left for an unsupported TLP");
    finish_test("unsupported_tlp", err_start);
  endtask

  task automatic back_pressure();
    int          err_start;
    int          n;
    int          xfer_start;
    logic [15:0] drop_start;
    logic [31:0] pend [$];  // {rid, tag, idx} in request order
    logic [31:0] p;
    err_start  = err_cnt;
    xfer_start = xfer_cnt;
    n = 0;
    tx_st_ready_i = 1'b0;
    while (rx_st_ready_o && n < 16) begin
      p = {16'($random(seed)), 8'(8'h80 + n), 8'(n % REG_NUM)};
      pend.push_back(p);
      read_reg(p[7:0], p[15:8], p[31:16]);
      n++;
    end
    if (rx_st_ready_o) report_error("rx_st_ready_o never dropped under back-pressure");
    // beats offered now must not be taken
    // the write aims at the register of the last queued read
    drop_start = rx_drop_cnt_o;
    offer_held_off(req_header(tlp_pkg::FT_MWR32, 10'd2, 16'h0100, 8'h00, 4'hF, 4'hF,
                              {21'h0, p[7:0], 3'b000}),
                   ~model[p[7:0]], 3'd0, 3);
    offer_held_off(req_header(8'h30, 10'd0, 16'h0003, 8'h90, 4'h0, 4'h0, 32'h0),
                   64'h0, 3'd0, 3);  // message
    step_cycle();
    if (rx_drop_cnt_o !== drop_start) begin
      report_mismatch("rx_drop_cnt_o", rx_drop_cnt_o, drop_start);
    end
    if (xfer_cnt != xfer_start) report_error("TX transfer while tx_st_ready_i was low");
    tx_st_ready_i = 1'b1;
    while (pend.size() > 0) begin
      p = pend.pop_front();
      expect_cpl(p[7:0], p[15:8], p[31:16]);
    end
    finish_test("back_pressure", err_start);
  endtask

  task automatic credit_report();
    int err_start;
    err_start = err_cnt;
    repeat (3) step_cycle();  // let the last pulse land
    if (xfer_cnt != cpl_cnt) report_mismatch("TX transfer count", xfer_cnt, cpl_cnt);
    if (cdt_cnt != xfer_cnt) report_mismatch("tx_cdt_valid_o pulse count", cdt_cnt, xfer_cnt);
    finish_test("credit_report", err_start);
  endtask

  task automatic ready_watchdog();
    int err_start;
    err_start = err_cnt;
    if (tx_rdy_timeout_o !== 1'b0) report_mismatch("tx_rdy_timeout_o", tx_rdy_timeout_o, 0);
    tx_st_ready_i = 1'b0;
    repeat (TIMEOUT - 1) step_cycle();
    if (tx_rdy_timeout_o !== 1'b0) report_mismatch("tx_rdy_timeout_o", tx_rdy_timeout_o, 0);
    repeat (3) step_cycle();
    if (tx_rdy_timeout_o !== 1'b1) report_mismatch("tx_rdy_timeout_o", tx_rdy_timeout_o, 1);
    tx_st_ready_i = 1'b1;
    repeat (4) step_cycle();
    if (tx_rdy_timeout_o !== 1'b1) report_mismatch("tx_rdy_timeout_o", tx_rdy_timeout_o, 1);
    finish_test("ready_watchdog", err_start);
  endtask

  // --------------------
  // run time limit
  initial begin
    repeat (RUN_CYCLES) @(posedge clk);
    $display("watchdog: run did not finish within %0d cycles", RUN_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    srstn          = 1'b0;
    rx_st_valid_i  = 1'b0;
    rx_st_sop_i    = 1'b0;
    rx_st_eop_i    = 1'b0;
    rx_st_header_i = '0;
    rx_st_data_i   = '0;
    rx_st_bar_i    = 3'd0;
    tx_st_ready_i  = 1'b1;
    for (int i = 0; i < REG_NUM; i++) begin
      model[i] = 64'h0;
    end
    repeat (RST_CYCLES) @(posedge clk);
    #1;
    srstn = 1'b1;
    step_cycle();
    check_reset_values();
    full_write_read();
    partial_write();
    unsupported_tlp();
    back_pressure();
    credit_report();
    ready_watchdog();  // runs last since the flag is sticky
    $display("summary: %0d tests, %0d errors", test_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- sim.f
hdl/tlp_pkg.sv
hdl/pio_pkg.sv
hdl/sync_fifo.sv
hdl/rx_decoder.sv
hdl/bar_regfile.sv
hdl/cpl_builder.sv
hdl/tx_port.sv
hdl/pio_top.sv
dv/pio_tb_assert.sv
dv/pio_tb.sv

//--- run.sh
#!/bin/sh
# build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module pio_tb \
  -f sim.f -o pio_sim &&
./obj_dir/pio_sim | tee /dev/stderr | grep -q "TEST PASSED" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
